/* src/exu_pkg.sv */
// ####################
// exu_pkg: shared widths, opcodes and types
// for the rv32 execute slice
// ####################
`default_nettype none

package exu_pkg;

    // datapath and index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // the one csr kept
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;

    // major opcodes handled by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct7 groups of the OP opcode
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // funct3 of the two csr instructions
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // which unit executes the instruction
    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_MUL, UNIT_CSR} unit_e;

    typedef enum logic {CSR_WRITE, CSR_SET} csr_op_e;

    // decode to execute, 89 bits
    typedef struct packed {
        logic                  valid;
        unit_e                 unit;
        alu_op_e               alu_op;
        csr_op_e               csr_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [CSR_ADDR_W-1:0] csr_addr;
    } dec_ctrl_t;

    // one register write, 38 bits
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } wb_req_t;

endpackage

`default_nettype wire

/* src/idu.sv */
// ####################
// idu: instruction decode
// register read and operand select
// ####################
`default_nettype none

module idu (
    input  wire [31:0]                     instr_i,
    input  wire                            instr_valid_i,
    output logic [exu_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [exu_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  wire  [exu_pkg::XLEN-1:0]       rs1_data_i,
    input  wire  [exu_pkg::XLEN-1:0]       rs2_data_i,
    output exu_pkg::dec_ctrl_t             ctrl_o
);

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [exu_pkg::REG_ADDR_W-1:0] rd;
    logic [exu_pkg::XLEN-1:0]       imm_i;
    logic                           supported;
    logic                           use_imm;
    logic                           issue;
    exu_pkg::unit_e                 unit;
    exu_pkg::alu_op_e               alu_op;
    exu_pkg::csr_op_e               csr_op;

    // fixed rv32 field positions
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // sign extended i-type immediate
    assign imm_i = {{(exu_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};

    // register file read, same cycle
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    always_comb begin
        supported = 1'b0;
        use_imm   = 1'b0;
        unit      = exu_pkg::UNIT_NONE;
        alu_op    = exu_pkg::ALU_ADD;
        csr_op    = exu_pkg::CSR_WRITE;
        case (opcode)
            exu_pkg::OPC_OP: begin
                unit = exu_pkg::UNIT_ALU;
                if (funct7 == exu_pkg::F7_MULDIV) begin
                    // low-word mul only, no division
                    unit      = exu_pkg::UNIT_MUL;
                    supported = (funct3 == 3'b000);
                end else if (funct7 == exu_pkg::F7_BASE) begin
                    supported = 1'b1;
                    case (funct3)
                        3'b000:  alu_op = exu_pkg::ALU_ADD;
                        3'b001:  alu_op = exu_pkg::ALU_SLL;
                        3'b010:  alu_op = exu_pkg::ALU_SLT;
                        3'b011:  alu_op = exu_pkg::ALU_SLTU;
                        3'b100:  alu_op = exu_pkg::ALU_XOR;
                        3'b101:  alu_op = exu_pkg::ALU_SRL;
                        3'b110:  alu_op = exu_pkg::ALU_OR;
                        default: alu_op = exu_pkg::ALU_AND;
                    endcase
                end else if (funct7 == exu_pkg::F7_ALT) begin
                    // sub and sra share the alternate funct7
                    supported = (funct3 == 3'b000) || (funct3 == 3'b101);
                    alu_op    = funct3[2] ? exu_pkg::ALU_SRA : exu_pkg::ALU_SUB;
                end
            end
            exu_pkg::OPC_OP_IMM: begin
                unit      = exu_pkg::UNIT_ALU;
                use_imm   = 1'b1;
                supported = 1'b1;
                case (funct3)
                    3'b000:  alu_op = exu_pkg::ALU_ADD;
                    3'b010:  alu_op = exu_pkg::ALU_SLT;
                    3'b100:  alu_op = exu_pkg::ALU_XOR;
                    3'b110:  alu_op = exu_pkg::ALU_OR;
                    3'b111:  alu_op = exu_pkg::ALU_AND;
                    // shifts by immediate and sltiu not kept
                    default: supported = 1'b0;
                endcase
            end
            exu_pkg::OPC_SYSTEM: begin
                unit      = exu_pkg::UNIT_CSR;
                supported = (funct3 == exu_pkg::F3_CSRRW) || (funct3 == exu_pkg::F3_CSRRS);
                csr_op    = (funct3 == exu_pkg::F3_CSRRS) ? exu_pkg::CSR_SET : exu_pkg::CSR_WRITE;
            end
            default: supported = 1'b0;
        endcase
    end

    // x0 target, bubble or bad encoding never issue
    assign issue = instr_valid_i & supported & (rd != '0);

    always_comb begin
        ctrl_o.valid    = issue;
        ctrl_o.unit     = issue ? unit : exu_pkg::UNIT_NONE;
        ctrl_o.alu_op   = alu_op;
        ctrl_o.csr_op   = csr_op;
        ctrl_o.rd       = rd;
        // rs1 is also the csr source
        ctrl_o.op_a     = rs1_data_i;
        ctrl_o.op_b     = use_imm ? imm_i : rs2_data_i;
        ctrl_o.csr_addr = instr_i[31:20];
    end

endmodule

`default_nettype wire

/* src/exu_mul.sv */
// ####################
// exu_mul: low-word multiplier
// one register stage, new op each cycle
// ####################
`default_nettype none

module exu_mul (
    input  wire                            clk,
    input  wire                            arst_n_i,
    input  wire                            valid_i,
    input  wire [exu_pkg::REG_ADDR_W-1:0]  rd_i,
    input  wire [exu_pkg::XLEN-1:0]        op_a_i,
    input  wire [exu_pkg::XLEN-1:0]        op_b_i,
    output exu_pkg::wb_req_t               req_o
);

    logic [exu_pkg::XLEN-1:0] prod_lo;
    exu_pkg::wb_req_t         req_q;

    // low 32 bits only, same for signed and unsigned
    assign prod_lo = op_a_i * op_b_i;

    // product travels with its destination and write flag
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
        end else begin
            req_q.we    <= valid_i;
            req_q.waddr <= rd_i;
            req_q.wdata <= prod_lo;
        end
    end

    assign req_o = req_q;

endmodule

`default_nettype wire

/* src/exu.sv */
// ####################
// exu: execute stage
// alu, mscratch csr and the multiplier
// ####################
`default_nettype none

module exu (
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire                exu_pkg::dec_ctrl_t ctrl_i,
    output exu_pkg::wb_req_t   alu_req_o,
    output exu_pkg::wb_req_t   csr_req_o,
    output exu_pkg::wb_req_t   mul_req_o
);

    logic                     issue_alu;
    logic                     issue_mul;
    logic                     issue_csr;
    logic [4:0]               shamt;
    logic [exu_pkg::XLEN-1:0] alu_res;
    logic [exu_pkg::XLEN-1:0] mscratch_q;

    // one-hot issue per unit
    assign issue_alu = ctrl_i.valid & (ctrl_i.unit == exu_pkg::UNIT_ALU);
    assign issue_mul = ctrl_i.valid & (ctrl_i.unit == exu_pkg::UNIT_MUL);
    // other csr addresses are not implemented, no write
    assign issue_csr = ctrl_i.valid & (ctrl_i.unit == exu_pkg::UNIT_CSR)
                     & (ctrl_i.csr_addr == exu_pkg::CSR_MSCRATCH);

    // shift amount from low bits of operand b
    assign shamt = ctrl_i.op_b[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            exu_pkg::ALU_ADD:  alu_res = ctrl_i.op_a + ctrl_i.op_b;
            exu_pkg::ALU_SUB:  alu_res = ctrl_i.op_a - ctrl_i.op_b;
            exu_pkg::ALU_AND:  alu_res = ctrl_i.op_a & ctrl_i.op_b;
            exu_pkg::ALU_OR:   alu_res = ctrl_i.op_a | ctrl_i.op_b;
            exu_pkg::ALU_XOR:  alu_res = ctrl_i.op_a ^ ctrl_i.op_b;
            exu_pkg::ALU_SLT: begin
                alu_res = {{(exu_pkg::XLEN-1){1'b0}},
                           $signed(ctrl_i.op_a) < $signed(ctrl_i.op_b)};
            end
            exu_pkg::ALU_SLTU: begin
                alu_res = {{(exu_pkg::XLEN-1){1'b0}}, ctrl_i.op_a < ctrl_i.op_b};
            end
            exu_pkg::ALU_SLL:  alu_res = ctrl_i.op_a << shamt;
            exu_pkg::ALU_SRL:  alu_res = ctrl_i.op_a >> shamt;
            // arithmetic shift keeps the sign
            exu_pkg::ALU_SRA:  alu_res = $signed(ctrl_i.op_a) >>> shamt;
            default:           alu_res = '0;
        endcase
    end

    // alu write, same cycle as issue
    assign alu_req_o.we    = issue_alu;
    assign alu_req_o.waddr = ctrl_i.rd;
    assign alu_req_o.wdata = alu_res;

    // mscratch, updated on the issue edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mscratch_q <= '0;
        end else if (issue_csr) begin
            if (ctrl_i.csr_op == exu_pkg::CSR_SET) begin
                mscratch_q <= mscratch_q | ctrl_i.op_a;
            end else begin
                mscratch_q <= ctrl_i.op_a;
            end
        end
    end

    // rd gets the value before the update
    assign csr_req_o.we    = issue_csr;
    assign csr_req_o.waddr = ctrl_i.rd;
    assign csr_req_o.wdata = mscratch_q;

    // registered multiply, result one cycle later
    exu_mul u_exu_mul (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (issue_mul),
        .rd_i     (ctrl_i.rd),
        .op_a_i   (ctrl_i.op_a),
        .op_b_i   (ctrl_i.op_b),
        .req_o    (mul_req_o)
    );

endmodule

`default_nettype wire

/* src/wbu.sv */
// ####################
// wbu: write-back unit
// delays results, picks one write per cycle
// ####################
`default_nettype none

module wbu (
    input  wire                clk,
    input  wire                arst_n_i,
    input  wire                exu_pkg::wb_req_t alu_req_i,
    input  wire                exu_pkg::wb_req_t csr_req_i,
    input  wire                exu_pkg::wb_req_t mul_req_i,
    input  wire                int_assert_i,
    output exu_pkg::wb_req_t   wb_o
);

    // one cycle delayed copies
    exu_pkg::wb_req_t alu_q;
    exu_pkg::wb_req_t csr_q;
    exu_pkg::wb_req_t mul_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_q <= '0;
            csr_q <= '0;
            mul_q <= '0;
        end else begin
            alu_q <= alu_req_i;
            csr_q <= csr_req_i;
            // mul is already one stage late, this makes two
            mul_q <= mul_req_i;
        end
    end

    // fixed priority mul > alu > csr
    // losers in a collision are dropped
    always_comb begin
        if (int_assert_i) begin
            // interrupt kills the register write only
            wb_o = '0;
        end else if (mul_q.we) begin
            wb_o = mul_q;
        end else if (alu_q.we) begin
            wb_o = alu_q;
        end else if (csr_q.we) begin
            wb_o = csr_q;
        end else begin
            // idle, drive zeros
            wb_o = '0;
        end
    end

endmodule

`default_nettype wire

/* src/regfile.sv */
// ####################
// regfile: 31 x 32 registers
// x0 reads zero, two async reads
// ####################
`default_nettype none

module regfile (
    input  wire                            clk,
    input  wire                            arst_n_i,
    input  wire                            exu_pkg::wb_req_t wb_i,
    input  wire [exu_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  wire [exu_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    output logic [exu_pkg::XLEN-1:0]       rs1_data_o,
    output logic [exu_pkg::XLEN-1:0]       rs2_data_o
);

    // no storage behind x0
    logic [exu_pkg::XLEN-1:0] regs_q [1:exu_pkg::NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < exu_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.waddr != '0)) begin
            regs_q[wb_i.waddr] <= wb_i.wdata;
        end
    end

    // no bypass, a write shows up the cycle after
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* src/core_top.sv */
// ####################
// core_top: rv32 execute slice
// decode, regfile, execute, write-back
// ####################
`default_nettype none

module core_top (
    input  wire                            clk,
    input  wire                            arst_n_i,
    input  wire [31:0]                     instr_i,
    input  wire                            instr_valid_i,
    input  wire                            int_assert_i,
    output logic                           reg_we_o,
    output logic [exu_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic [exu_pkg::XLEN-1:0]       reg_wdata_o
);

    logic [exu_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [exu_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [exu_pkg::XLEN-1:0]       rs1_data;
    logic [exu_pkg::XLEN-1:0]       rs2_data;
    exu_pkg::dec_ctrl_t             ctrl;
    exu_pkg::wb_req_t               alu_req;
    exu_pkg::wb_req_t               csr_req;
    exu_pkg::wb_req_t               mul_req;
    exu_pkg::wb_req_t               wb;

    idu u_idu (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ctrl_o        (ctrl)
    );

    regfile u_regfile (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .wb_i       (wb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exu u_exu (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ctrl_i    (ctrl),
        .alu_req_o (alu_req),
        .csr_req_o (csr_req),
        .mul_req_o (mul_req)
    );

    wbu u_wbu (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .alu_req_i    (alu_req),
        .csr_req_i    (csr_req),
        .mul_req_i    (mul_req),
        .int_assert_i (int_assert_i),
        .wb_o         (wb)
    );

    // ports mirror the write the regfile takes this edge
    assign reg_we_o    = wb.we;
    assign reg_waddr_o = wb.waddr;
    assign reg_wdata_o = wb.wdata;

endmodule

`default_nettype wire

/* tb/tb_core_top.sv */
// ####################
// tb_core_top: testbench for the rv32 execute slice
// random alu, mul and csr traffic against a reference model
// ####################
`default_nettype none

module tb_core_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int N_ALU = 40;
    localparam int N_MUL = 10;
    localparam int N_CSR = 10;
    localparam int N_PRI = 6;
    localparam int N_IRQ = 6;
    // cycles per test, drains of 3 included
    localparam int TEST_CYCLES = (5 + 2 + 31 + 3) + (15 + 2 + N_ALU * 3 + 3) + (N_MUL * 4 + 3)
                               + (N_CSR * 3 + 3) + (N_PRI * 7 + 3) + (N_IRQ * 6 + 6 + 3);
    localparam int MAX_CYC = TEST_CYCLES + 100;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic        int_assert_i;
    logic        reg_we_o;
    logic [4:0]  reg_waddr_o;
    logic [31:0] reg_wdata_o;

    // reference state and expected writes, indexed by cycle
    logic [31:0]      model_regs [0:31];
    logic [31:0]      model_msc;
    exu_pkg::wb_req_t exp_wb    [0:MAX_CYC-1];
    int               exp_rank  [0:MAX_CYC-1];
    bit               squash_at [0:MAX_CYC-1];
    int               cyc = 0;
    int               pass_cnt = 0;
    int               fail_cnt = 0;
    int               fails_at_start = 0;

    core_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .int_assert_i  (int_assert_i),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // cycle number, read old value at the edge
    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // nonzero register from 4 random bits
    function automatic logic [4:0] nz_reg(input logic [3:0] v);
        return (v == 4'd0) ? 5'd15 : {1'b0, v};
    endfunction

    // rv32 funct3 semantics, alt selects sub and sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // expected write, latency and priority rank of one instruction
    function automatic exu_pkg::wb_req_t predict(input logic [31:0] instr,
                                                 input logic [31:0] a,
                                                 input logic [31:0] rs2_val,
                                                 input logic [31:0] msc,
                                                 output int lat, output int rank,
                                                 output logic [31:0] msc_next);
        logic [6:0]       opc;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [31:0]      imm;
        logic             ok;
        exu_pkg::wb_req_t w;
        opc = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        imm = {{20{instr[31]}}, instr[31:20]};
        ok = 1'b0;
        lat = 1;
        rank = 2;
        msc_next = msc;
        w = '0;
        w.waddr = instr[11:7];
        if (opc == exu_pkg::OPC_OP) begin
            if (f7 == 7'h01) begin
                // mul, one extra stage, top priority
                ok = (f3 == 3'd0);
                w.wdata = a * rs2_val;
                lat = 2;
                rank = 3;
            end else if (f7 == 7'h00 || f7 == 7'h20) begin
                ok = (f7 == 7'h00) || (f3 == 3'd0) || (f3 == 3'd5);
                w.wdata = alu_ref(f3, f7[5], a, rs2_val);
            end
        end else if (opc == exu_pkg::OPC_OP_IMM) begin
            ok = (f3 == 3'd0) || (f3 == 3'd2) || (f3 == 3'd4) || (f3 == 3'd6) || (f3 == 3'd7);
            w.wdata = alu_ref(f3, 1'b0, a, imm);
        end else if (opc == exu_pkg::OPC_SYSTEM) begin
            // csr read returns old mscratch
            rank = 1;
            ok = (instr[31:20] == 12'h340) && ((f3 == 3'd1) || (f3 == 3'd2));
            w.wdata = msc;
            if (ok && instr[11:7] != 5'd0) begin
                msc_next = (f3 == 3'd2) ? (msc | a) : a;
            end
        end
        // x0 target never writes
        w.we = ok && (instr[11:7] != 5'd0);
        return w;
    endfunction

    function automatic logic [31:0] alu_instr(input int k, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        case (k)
            0: return enc_r(7'h00, rs2, rs1, 3'd0, rd, exu_pkg::OPC_OP);
            1: return enc_r(7'h20, rs2, rs1, 3'd0, rd, exu_pkg::OPC_OP);
            2: return enc_r(7'h00, rs2, rs1, 3'd7, rd, exu_pkg::OPC_OP);
            3: return enc_r(7'h00, rs2, rs1, 3'd6, rd, exu_pkg::OPC_OP);
            4: return enc_r(7'h00, rs2, rs1, 3'd4, rd, exu_pkg::OPC_OP);
            5: return enc_r(7'h00, rs2, rs1, 3'd2, rd, exu_pkg::OPC_OP);
            6: return enc_r(7'h00, rs2, rs1, 3'd3, rd, exu_pkg::OPC_OP);
            7: return enc_r(7'h00, rs2, rs1, 3'd1, rd, exu_pkg::OPC_OP);
            8: return enc_r(7'h00, rs2, rs1, 3'd5, rd, exu_pkg::OPC_OP);
            9: return enc_r(7'h20, rs2, rs1, 3'd5, rd, exu_pkg::OPC_OP);
            10: return enc_i(imm, rs1, 3'd0, rd, exu_pkg::OPC_OP_IMM);
            11: return enc_i(imm, rs1, 3'd7, rd, exu_pkg::OPC_OP_IMM);
            12: return enc_i(imm, rs1, 3'd6, rd, exu_pkg::OPC_OP_IMM);
            13: return enc_i(imm, rs1, 3'd4, rd, exu_pkg::OPC_OP_IMM);
            default: return enc_i(imm, rs1, 3'd2, rd, exu_pkg::OPC_OP_IMM);
        endcase
    endfunction

    // one clock of stimulus, expected write booked by due cycle
    task automatic drive_cycle(input logic valid, input logic [31:0] instr, input logic irq);
        exu_pkg::wb_req_t w;
        int               lat;
        int               rank;
        int               due;
        logic [31:0]      msc_next;
        @(posedge clk);
        instr_valid_i <= valid;
        instr_i <= instr;
        int_assert_i <= irq;
        if (irq) squash_at[cyc + 1] = 1'b1;
        if (valid) begin
            w = predict(instr, model_regs[instr[19:15]], model_regs[instr[24:20]], model_msc,
                        lat, rank, msc_next);
            // mscratch moves at the issue edge
            model_msc = msc_next;
            due = cyc + 1 + lat;
            // collision, higher rank wins
            if (w.we && (!exp_wb[due].we || rank > exp_rank[due])) begin
                exp_wb[due] = w;
                exp_rank[due] = rank;
            end
        end
    endtask

    task automatic issue(input logic [31:0] instr);
        drive_cycle(1'b1, instr, 1'b0);
    endtask

    // bubbles carry random junk on instr_i
    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            drive_cycle(1'b0, $urandom, 1'b0);
        end
    endtask

    // two bubbles so the next op sees the result
    task automatic exec_op(input logic [31:0] instr);
        issue(instr);
        idle(2);
    endtask

    task automatic begin_test();
        fails_at_start = fail_cnt;
    endtask

    task automatic end_test(input string name);
        idle(3);
        $display("test %-9s done, %0d failures", name, fail_cnt - fails_at_start);
    endtask

    // mid-cycle sample of the write-back ports
    always @(negedge clk) begin : compare
        exu_pkg::wb_req_t want;
        want = '0;
        if (cyc < MAX_CYC && !squash_at[cyc]) want = exp_wb[cyc];
        if (want.we) begin
            assert (reg_we_o === 1'b1) pass_cnt = pass_cnt + 1;
            else begin
                fail_cnt = fail_cnt + 1;
                $display("write of %08h to x%0d missing in cycle %0d at %0t",
                         want.wdata, want.waddr, cyc, $time);
            end
            if (reg_we_o === 1'b1) begin
                assert (reg_waddr_o === want.waddr && reg_wdata_o === want.wdata)
                    pass_cnt = pass_cnt + 1;
                else begin
                    fail_cnt = fail_cnt + 1;
                    $display("ERR %0t: expected x%0d=%08h, seen x%0d=%08h", $time,
                             want.waddr, want.wdata, reg_waddr_o, reg_wdata_o);
                end
            end
            model_regs[want.waddr] = want.wdata;
        end else begin
            assert (reg_we_o === 1'b0) pass_cnt = pass_cnt + 1;
            else begin
                fail_cnt = fail_cnt + 1;
                $display("unexpected write of %08h to x%0d in cycle %0d at %0t",
                         reg_wdata_o, reg_waddr_o, cyc, $time);
            end
        end
    end

    // run limit from the total test length
    initial begin : watchdog
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired, run did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] rnd;
        logic [4:0]  rd;
        int          k;
        clk = 1'b0;
        arst_n_i = 1'b0;
        instr_i = '0;
        instr_valid_i = 1'b0;
        int_assert_i = 1'b0;
        rnd = $urandom(32'h6a38);
        model_msc = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < MAX_CYC; i++) begin
            exp_wb[i] = '0;
            exp_rank[i] = 0;
            squash_at[i] = 1'b0;
        end

        // reset, then read every register back as zero
        begin_test();
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        idle(2);
        for (int r = 1; r < 32; r++) issue(enc_i(12'h000, 5'(r), 3'd0, 5'(r), exu_pkg::OPC_OP_IMM));
        end_test("reset");

        // load x1..x15, then every alu op in turn, some aimed at x0
        begin_test();
        for (int r = 1; r < 16; r++) begin
            rnd = $urandom;
            issue(enc_i(rnd[11:0], 5'd0, 3'd0, 5'(r), exu_pkg::OPC_OP_IMM));
        end
        idle(2);
        for (int n = 0; n < N_ALU; n++) begin
            rnd = $urandom;
            k = n % 15;
            rd = (n % 8 == 0) ? 5'd0 : {1'b0, rnd[3:0]};
            exec_op(alu_instr(k, rd, {1'b0, rnd[7:4]}, {1'b0, rnd[11:8]}, rnd[23:12]));
        end
        end_test("alu");

        // multiplies in back-to-back pairs
        begin_test();
        for (int n = 0; n < N_MUL; n++) begin
            rnd = $urandom;
            issue(enc_r(7'h01, {1'b0, rnd[11:8]}, {1'b0, rnd[7:4]}, 3'd0, nz_reg(rnd[3:0]),
                        exu_pkg::OPC_OP));
            issue(enc_r(7'h01, {1'b0, rnd[23:20]}, {1'b0, rnd[19:16]}, 3'd0,
                        nz_reg(rnd[15:12]), exu_pkg::OPC_OP));
            idle(2);
        end
        end_test("mul");

        // csrrw and csrrs on mscratch
        begin_test();
        for (int n = 0; n < N_CSR; n++) begin
            rnd = $urandom;
            exec_op(enc_i(12'h340, {1'b0, rnd[7:4]}, rnd[0] ? 3'd2 : 3'd1, nz_reg(rnd[11:8]),
                          exu_pkg::OPC_SYSTEM));
        end
        end_test("csr");

        // mul then alu one cycle later, alu write lost
        begin_test();
        for (int n = 0; n < N_PRI; n++) begin
            rnd = $urandom;
            rd = {1'b1, rnd[7:4]};
            issue(enc_r(7'h01, {1'b0, rnd[15:12]}, {1'b0, rnd[11:8]}, 3'd0, nz_reg(rnd[3:0]),
                        exu_pkg::OPC_OP));
            issue(enc_i(rnd[27:16], 5'd0, 3'd0, rd, exu_pkg::OPC_OP_IMM));
            idle(2);
            exec_op(enc_i(12'h000, rd, 3'd0, rd, exu_pkg::OPC_OP_IMM));
        end
        end_test("priority");

        // interrupt in the write-back cycle
        begin_test();
        for (int n = 0; n < N_IRQ; n++) begin
            rnd = $urandom;
            rd = nz_reg(rnd[3:0]);
            issue(enc_i(rnd[15:4], 5'd0, 3'd0, rd, exu_pkg::OPC_OP_IMM));
            drive_cycle(1'b0, $urandom, 1'b1);
            idle(1);
            exec_op(enc_i(12'h000, rd, 3'd0, rd, exu_pkg::OPC_OP_IMM));
        end
        // squashed csrrw, mscratch still updated
        rnd = $urandom;
        issue(enc_i(12'h340, nz_reg(rnd[3:0]), 3'd1, 5'd10, exu_pkg::OPC_SYSTEM));
        drive_cycle(1'b0, $urandom, 1'b1);
        idle(1);
        exec_op(enc_i(12'h340, 5'd0, 3'd2, 5'd11, exu_pkg::OPC_SYSTEM));
        end_test("interrupt");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
src/exu_pkg.sv
src/idu.sv
src/exu_mul.sv
src/exu.sv
src/wbu.sv
src/regfile.sv
src/core_top.sv
tb/tb_core_top.sv

/* Bender.yml */
package:
  name: rv32_exu_slice

sources:
  - files:
      - src/exu_pkg.sv
      - src/idu.sv
      - src/exu_mul.sv
      - src/exu.sv
      - src/wbu.sv
      - src/regfile.sv
      - src/core_top.sv
  - target: test
    files:
      - tb/tb_core_top.sv
